/* instruction_decoder.f */
decoder_pkg.sv
decoder_ifs.sv
cycle_counter.sv
datapath_decoder.sv
address_decoder.sv
control_register.sv
instruction_decoder.sv
tb_clock.sv
instruction_decoder_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
LINT      = --lint-only --timing
TOP       = instruction_decoder_tb
FILELIST  = instruction_decoder.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* instruction_decoder_tb.sv */
`timescale 1ns/10ps

module instruction_decoder_tb;
	import decoder_pkg::*;

	localparam int CYCLE_W  = 3;
	localparam int N_INSTR  = 200;
	localparam int WATCH_NS = (N_INSTR * 4 + 40) * 8; // longest instruction is 4 cycles

	// kept set plus one draw slot that gives an arbitrary byte
	localparam logic [7:0] KEPT_OPS [14] = '{ADC_IMM, SBC_IMM, ADC_ZPG, ADC_ABS, SEC, CLC,
		INX, INY, DEX, DEY, TAX, TXA, TAY, TYA};

	logic                 clk_ph2;
	logic                 rst;
	logic [7:0]           ir;
	logic [REG_BUS_W-1:0] reg_bus;
	logic [ALU_IN_W-1:0]  alu_in;
	logic                 sums;
	logic [FLAG_W-1:0]    flag_load;
	logic [ADDR_W-1:0]    addr_drive;
	logic [PC_W-1:0]      pc_ctl;
	logic [CYCLE_W-1:0]   cycle;

	logic [7:0]         prev_ir  = 8'h00; // opcode behind the word now on the outputs
	logic [CYCLE_W-1:0] prev_cyc = '0;    // model cycle behind that word
	logic               prev_rst = 1'b0;
	logic [CYCLE_W-1:0] exp_cyc  = '0;    // model cycle counter
	logic [CYCLE_W-1:0] cyc_seen = '0;    // dut cycle sampled mid cycle
	int                 ticks    = 0;
	int                 pcyc;
	logic               live;             // outputs hold a decoded word
	logic [CTL_W+CYCLE_W-1:0] all_out;
	integer             seed     = 32'hc66c_7370;
	int                 err_count [string];

	assign pcyc    = int'(prev_cyc);
	assign live    = (ticks >= 1) && prev_rst;
	assign all_out = {reg_bus, alu_in, sums, flag_load, addr_drive, pc_ctl, cycle};

	tb_clock clock_gen (
		.clk_ph2 (clk_ph2),
		.rst     (rst)
	);

	instruction_decoder #(
		.CYCLE_W (CYCLE_W)
	) instruction_decoder_inst (
		.clk_ph2    (clk_ph2),
		.rst        (rst),
		.ir         (ir),
		.reg_bus    (reg_bus),
		.alu_in     (alu_in),
		.sums       (sums),
		.flag_load  (flag_load),
		.addr_drive (addr_drive),
		.pc_ctl     (pc_ctl),
		.cycle      (cycle)
	);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic logic is_add(input logic [7:0] op);
		return op inside {ADC_IMM, SBC_IMM, ADC_ZPG, ADC_ABS};
	endfunction

	function automatic logic is_incdec(input logic [7:0] op);
		return op inside {INX, INY, DEX, DEY};
	endfunction

	function automatic logic is_transfer(input logic [7:0] op);
		return op inside {TAX, TXA, TAY, TYA};
	endfunction

	function automatic int instr_len(input logic [7:0] op);
		case (op)
			ADC_ZPG: return 3;
			ADC_ABS: return 4;
			default: return 2; // implied, immediate, unknown
		endcase
	endfunction

	function automatic logic [CYCLE_W-1:0] next_cycle(input logic [7:0] op,
		input logic [CYCLE_W-1:0] c);
		if (int'(c) + 1 < instr_len(op)) begin
			return c + CYCLE_W'(1);
		end
		return '0;
	endfunction

	// pc goes out except for the operand address cycles
	function automatic logic pc_fetch(input logic [7:0] op, input int c);
		return !((op == ADC_ZPG && c == 1) || (op == ADC_ABS && c == 2));
	endfunction

	function automatic logic [FLAG_W-1:0] flag_loads(input logic [7:0] op, input int c);
		logic [FLAG_W-1:0] f;
		f = '0;
		if (c == 0 && is_add(op)) begin
			f[FLG_AVR_V] = 1'b1; // result store loads all four flags
			f[FLG_ACR_C] = 1'b1;
		end
		if ((c == 0 && (is_add(op) || is_incdec(op))) || (c == 1 && is_transfer(op))) begin
			f[FLG_DBZ_Z] = 1'b1;
			f[FLG_DB7_N] = 1'b1;
		end
		f[FLG_IR5_C] = (c == 1) && (op inside {SEC, CLC}); // carry comes from op[5]
		return f;
	endfunction

	function automatic logic [ADDR_W-1:0] addr_sources(input logic [7:0] op, input int c);
		logic [ADDR_W-1:0] a;
		a = '0;
		a[ADR_ADL_ABL] = 1'b1;
		a[ADR_ADH_ABH] = 1'b1;
		if (op == ADC_ZPG && c == 1) begin
			a[ADR_DL_ADL] = 1'b1; // page zero
			a[ADR_Z_ADH]  = 1'b1;
		end else if (op == ADC_ABS && c == 2) begin
			a[ADR_ADD_ADL] = 1'b1;
			a[ADR_DL_ADH]  = 1'b1;
		end else begin
			a[ADR_PCL_ADL] = 1'b1;
			a[ADR_PCH_ADH] = 1'b1;
		end
		return a;
	endfunction

	function automatic logic [PC_W-1:0] pc_controls(input logic [7:0] op, input int c);
		logic [PC_W-1:0] p;
		p = '0;
		if (pc_fetch(op, c)) begin
			p[PC_PCL_PCL] = 1'b1;
			p[PC_PCH_PCH] = 1'b1;
			p[PC_I_PC]    = !(c == 0 && (is_transfer(op) || is_incdec(op) ||
				op inside {SEC, CLC})); // single byte so pc stays
		end
		return p;
	endfunction

	// source and destination lines a register write needs
	function automatic logic [REG_BUS_W-1:0] written_regs(input logic [7:0] op, input int c);
		logic [REG_BUS_W-1:0] m;
		m = '0;
		if (c == 0) begin
			m[BUS_ADD_SB] = is_add(op) || is_incdec(op);
			m[BUS_SB_AC]  = is_add(op);
			m[BUS_SB_X]   = op inside {INX, DEX};
			m[BUS_SB_Y]   = op inside {INY, DEY};
		end else if (c == 1) begin
			m[BUS_AC_SB] = op inside {TAX, TAY};
			m[BUS_SB_X]  = (op == TAX);
			m[BUS_SB_Y]  = (op == TAY);
			m[BUS_X_SB]  = op inside {TXA, INX, DEX};
			m[BUS_Y_SB]  = op inside {TYA, INY, DEY};
			m[BUS_SB_AC] = op inside {TXA, TYA};
		end
		return m;
	endfunction

	// z_add, none_add, c_one, sums
	function automatic logic [3:0] incdec_inputs(input logic [7:0] op);
		return {op inside {INX, INY}, op inside {DEX, DEY}, 1'b1, 1'b1};
	endfunction

	// sb_add, db_add, ndb_add, sums
	function automatic logic [3:0] add_inputs(input logic [7:0] op);
		return {1'b1, op != SBC_IMM, op == SBC_IMM, 1'b1};
	endfunction

	always @(posedge clk_ph2) begin
		ticks    <= ticks + 1;
		prev_ir  <= ir;
		prev_cyc <= exp_cyc;
		prev_rst <= rst;
		exp_cyc  <= rst ? next_cycle(ir, exp_cyc) : '0;
	end

	always @(negedge clk_ph2) begin
		cyc_seen <= cycle; // stable half way through the cycle
	end

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Fail %s at %0t: expected %0h, actual %0h", name, $time, expected, actual);
		err_count[name]++;
	endtask

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	a_reset: assert property (@(posedge clk_ph2) (ticks >= 1 && !prev_rst) |-> all_out == '0)
		else report_mismatch("reset", 64'd0, 64'($sampled(all_out)));
	a_cycle: assert property (@(posedge clk_ph2) (ticks >= 1) |-> cycle == exp_cyc)
		else report_mismatch("cycle", 64'($sampled(exp_cyc)), 64'($sampled(cycle)));
	a_flags: assert property (@(posedge clk_ph2) live |-> flag_load == flag_loads(prev_ir, pcyc))
		else report_mismatch("flags", 64'(flag_loads($sampled(prev_ir), $sampled(pcyc))),
			64'($sampled(flag_load)));
	a_addr: assert property (@(posedge clk_ph2)
		live |-> addr_drive == addr_sources(prev_ir, pcyc))
		else report_mismatch("address", 64'(addr_sources($sampled(prev_ir), $sampled(pcyc))),
			64'($sampled(addr_drive)));
	a_pc: assert property (@(posedge clk_ph2) live |-> pc_ctl == pc_controls(prev_ir, pcyc))
		else report_mismatch("pc", 64'(pc_controls($sampled(prev_ir), $sampled(pcyc))),
			64'($sampled(pc_ctl)));
	a_write: assert property (@(posedge clk_ph2) (live && written_regs(prev_ir, pcyc) != '0)
		|-> (reg_bus & written_regs(prev_ir, pcyc)) == written_regs(prev_ir, pcyc))
		else report_mismatch("reg_write",
			64'(written_regs($sampled(prev_ir), $sampled(pcyc))),
			64'($sampled(reg_bus) & written_regs($sampled(prev_ir), $sampled(pcyc))));
	a_incdec: assert property (@(posedge clk_ph2) (live && pcyc == 1 && is_incdec(prev_ir))
		|-> {alu_in[ALU_Z_ADD], alu_in[ALU_NONE_ADD], alu_in[ALU_C_ONE], sums}
			== incdec_inputs(prev_ir))
		else report_mismatch("incdec", 64'(incdec_inputs($sampled(prev_ir))),
			64'($sampled({alu_in[ALU_Z_ADD], alu_in[ALU_NONE_ADD], alu_in[ALU_C_ONE], sums})));
	a_add: assert property (@(posedge clk_ph2)
		(live && is_add(prev_ir) && pcyc == instr_len(prev_ir) - 1)
		|-> {alu_in[ALU_SB_ADD], alu_in[ALU_DB_ADD], alu_in[ALU_NDB_ADD], sums}
			== add_inputs(prev_ir))
		else report_mismatch("alu_add", 64'(add_inputs($sampled(prev_ir))),
			64'($sampled({alu_in[ALU_SB_ADD], alu_in[ALU_DB_ADD], alu_in[ALU_NDB_ADD], sums})));

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	function automatic logic [7:0] next_opcode();
		int slot;
		slot = int'($unsigned($random(seed)) % 15);
		if (slot < 14) begin
			return KEPT_OPS[slot];
		end
		return 8'($random(seed)); // mostly not a recognised opcode
	endfunction

	initial begin
		int n;
		int total;
		string counts;
		ir = TAX;
		total = 0;
		counts = "";
		wait (rst == 1'b1);
		for (n = 0; n < N_INSTR; n++) begin
			@(posedge clk_ph2);
			while (cyc_seen != '0) @(posedge clk_ph2); // previous instruction back at 0
			ir <= next_opcode(); // new opcode from cycle 1 on
		end
		@(posedge clk_ph2);
		while (cyc_seen != '0) @(posedge clk_ph2);
		@(posedge clk_ph2); // last cycle 0 word checked
		@(negedge clk_ph2); // checks of that edge have run
		foreach (err_count[name]) begin
			total += err_count[name];
			counts = {counts, $sformatf(" %s=%0d", name, err_count[name])};
		end
		$display("errors: %0d total%s", total, counts);
		if (total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(WATCH_NS);
		$display("watchdog: run did not finish within %0d ns", WATCH_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
	parameter int HALF_NS    = 4, // 8 ns period
	parameter int RST_CYCLES = 2
) (
	output logic clk_ph2,
	output logic rst // active low
);

	initial begin
		clk_ph2 = 1'b0;
		forever #(HALF_NS) clk_ph2 = ~clk_ph2;
	end

	initial begin
		rst = 1'b0; // held over the first edges
		repeat (RST_CYCLES) @(posedge clk_ph2);
		rst <= 1'b1;
	end

endmodule

/* instruction_decoder.sv */
`timescale 1ns/10ps

module instruction_decoder #(
	parameter int CYCLE_W = 3 // 2 or more holds cycles 0..3
) (
	input  logic                              clk_ph2,
	input  logic                              rst,  // active low
	input  logic [7:0]                        ir,   // held for the whole instruction
	output logic [decoder_pkg::REG_BUS_W-1:0] reg_bus,
	output logic [decoder_pkg::ALU_IN_W-1:0]  alu_in,
	output logic                              sums,
	output logic [decoder_pkg::FLAG_W-1:0]    flag_load,
	output logic [decoder_pkg::ADDR_W-1:0]    addr_drive,
	output logic [decoder_pkg::PC_W-1:0]      pc_ctl,
	output logic [CYCLE_W-1:0]                cycle
);

	datapath_ctl_if dp_if ();
	address_ctl_if  ad_if ();

	logic step_inc; // counter step, from the control register
	logic step_rst;

	cycle_counter #(
		.CYCLE_W (CYCLE_W)
	) cycle_counter_inst (
		.clk_ph2  (clk_ph2),
		.rst      (rst),
		.step_inc (step_inc),
		.step_rst (step_rst),
		.cycle    (cycle)
	);

	datapath_decoder #(
		.CYCLE_W (CYCLE_W)
	) datapath_decoder_inst (
		.cycle (cycle),
		.ir    (ir),
		.dp    (dp_if)
	);

	address_decoder #(
		.CYCLE_W (CYCLE_W)
	) address_decoder_inst (
		.cycle (cycle),
		.ir    (ir),
		.ad    (ad_if)
	);

	control_register control_register_inst (
		.clk_ph2    (clk_ph2),
		.rst        (rst),
		.dp         (dp_if),
		.ad         (ad_if),
		.reg_bus    (reg_bus),
		.alu_in     (alu_in),
		.sums       (sums),
		.flag_load  (flag_load),
		.addr_drive (addr_drive),
		.pc_ctl     (pc_ctl),
		.step_inc   (step_inc),
		.step_rst   (step_rst)
	);

endmodule

/* control_register.sv */
`timescale 1ns/10ps

module control_register (
	input  logic                              clk_ph2,
	input  logic                              rst, // active low
	datapath_ctl_if.dst                       dp,
	address_ctl_if.dst                        ad,
	output logic [decoder_pkg::REG_BUS_W-1:0] reg_bus,
	output logic [decoder_pkg::ALU_IN_W-1:0]  alu_in,
	output logic                              sums,
	output logic [decoder_pkg::FLAG_W-1:0]    flag_load,
	output logic [decoder_pkg::ADDR_W-1:0]    addr_drive,
	output logic [decoder_pkg::PC_W-1:0]      pc_ctl,
	output logic                              step_inc, // to cycle counter, same cycle
	output logic                              step_rst
);
	import decoder_pkg::*;

	logic [CTL_W-1:0] ctl_d; // both halves, decoded from this cycle
	logic [CTL_W-1:0] ctl_q; // word for the next bus cycle

	assign ctl_d = {dp.reg_bus, dp.alu_in, dp.sums, dp.flag_load, ad.addr_drive, ad.pc_ctl};

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			ctl_q <= '0; // all lines idle
		end else begin
			ctl_q <= ctl_d;
		end
	end

	assign {reg_bus, alu_in, sums, flag_load, addr_drive, pc_ctl} = ctl_q;

	assign step_inc = ad.step_inc; // counter moves at the same edge as ctl_q
	assign step_rst = ad.step_rst;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_step_onehot: assert property (@(posedge clk_ph2) disable iff (!rst)
		ad.step_inc ^ ad.step_rst)
		else $error("control_register: step not one-hot");

	// sb has one driver at a time, across both decoder halves
	a_sb_one_src: assert property (@(posedge clk_ph2) disable iff (!rst)
		$countones({reg_bus[BUS_AC_SB], reg_bus[BUS_ADD_SB],
			reg_bus[BUS_X_SB], reg_bus[BUS_Y_SB]}) <= 1)
		else $error("control_register: sb driven by %b", reg_bus);

	a_pc_latched: assert property (@(posedge clk_ph2) disable iff (!rst)
		addr_drive[ADR_PCL_ADL] |-> addr_drive[ADR_ADL_ABL] && addr_drive[ADR_ADH_ABH])
		else $error("control_register: pc on adl but not latched");

endmodule

/* address_decoder.sv */
`timescale 1ns/10ps

module address_decoder #(
	parameter int CYCLE_W = 3
) (
	input  logic [CYCLE_W-1:0] cycle,
	input  decoder_pkg::opcode_u ir,
	address_ctl_if.src         ad
);
	import decoder_pkg::*;

	logic             alu_op;    // adc/sbc in a kept mode
	logic [CYCLE_W-1:0] last_cyc; // final cycle of the alu instruction
	logic             zpg_addr;  // zero page operand address out
	logic             abs_addr;  // absolute operand address out
	logic             one_byte;  // opcode fetch of a single byte instruction

	assign alu_op   = is_alu_op(ir);
	assign last_cyc = CYCLE_W'(alu_last_cycle(ir));
	assign zpg_addr = alu_op && (ir.f.bbb == BBB_ZPG) && (cycle == CYCLE_W'(CYC_OPND));
	assign abs_addr = alu_op && (ir.f.bbb == BBB_ABS) && (cycle == CYCLE_W'(CYC_ADDR));
	assign one_byte = is_implied(ir) && (cycle == CYCLE_W'(CYC_FETCH));

	////////////////////////////////////////
	// cycle step
	////////////////////////////////////////
	always_comb begin
		ad.step_inc = 1'b0;
		ad.step_rst = 1'b0;
		if (cycle == CYCLE_W'(CYC_FETCH)) begin
			ad.step_inc = 1'b1; // every opcode has a cycle 1
		end else if (alu_op && (cycle < last_cyc)) begin
			ad.step_inc = 1'b1; // more operand cycles to go
		end else begin
			ad.step_rst = 1'b1; // implied, imm, last cycle or unknown opcode
		end
	end

	////////////////////////////////////////
	// address bus source for the next cycle
	////////////////////////////////////////
	always_comb begin
		ad.addr_drive = '0;
		ad.pc_ctl     = '0;
		ad.addr_drive[ADR_ADL_ABL] = 1'b1; // address latched every cycle
		ad.addr_drive[ADR_ADH_ABH] = 1'b1;
		if (zpg_addr) begin
			ad.addr_drive[ADR_DL_ADL] = 1'b1; // 00:dl
			ad.addr_drive[ADR_Z_ADH]  = 1'b1;
		end else if (abs_addr) begin
			ad.addr_drive[ADR_ADD_ADL] = 1'b1; // dl:add, low byte parked in alu
			ad.addr_drive[ADR_DL_ADH]  = 1'b1;
		end else begin
			ad.addr_drive[ADR_PCL_ADL] = 1'b1; // pc out
			ad.addr_drive[ADR_PCH_ADH] = 1'b1;
			ad.pc_ctl[PC_PCL_PCL] = 1'b1;
			ad.pc_ctl[PC_PCH_PCH] = 1'b1;
			// one byte opcode, next fetch reads the following opcode again
			ad.pc_ctl[PC_I_PC] = !one_byte;
		end
	end

endmodule

/* datapath_decoder.sv */
`timescale 1ns/10ps

module datapath_decoder #(
	parameter int CYCLE_W = 3
) (
	input  logic [CYCLE_W-1:0] cycle,
	input  decoder_pkg::opcode_u ir,
	datapath_ctl_if.src        dp
);
	import decoder_pkg::*;

	logic alu_op;   // adc/sbc in a kept mode
	logic alu_add;  // this cycle does the adc/sbc add
	logic carry_op; // sec or clc

	assign alu_op  = is_alu_op(ir);
	assign alu_add = alu_op && (cycle == CYCLE_W'(alu_last_cycle(ir)));
	// flag group: cc 00, bbb 110, aaa 00x, aaa[0] is the carry value itself
	assign carry_op = (ir.f.cc == 2'b00) && (ir.f.bbb == 3'b110) && (ir.f.aaa[2:1] == 2'b00);

	always_comb begin
		dp.reg_bus   = '0;
		dp.alu_in    = '0;
		dp.sums      = 1'b0;
		dp.flag_load = '0;

		case (cycle)
			////////////////////////////////////////
			// cycle 0, store the previous result
			////////////////////////////////////////
			CYCLE_W'(CYC_FETCH): begin
				if (alu_op) begin
					dp.reg_bus[BUS_ADD_SB] = 1'b1; // add -> sb -> ac
					dp.reg_bus[BUS_SB_AC]  = 1'b1;
					dp.reg_bus[BUS_SB_DB]  = 1'b1; // db for n/z
					dp.flag_load[FLG_AVR_V] = 1'b1;
					dp.flag_load[FLG_ACR_C] = 1'b1;
					dp.flag_load[FLG_DBZ_Z] = 1'b1;
					dp.flag_load[FLG_DB7_N] = 1'b1;
				end
				case (ir.raw)
					INX, DEX: begin
						dp.reg_bus[BUS_ADD_SB] = 1'b1; // add -> x
						dp.reg_bus[BUS_SB_X]   = 1'b1;
						dp.reg_bus[BUS_SB_DB]  = 1'b1;
						dp.flag_load[FLG_DBZ_Z] = 1'b1;
						dp.flag_load[FLG_DB7_N] = 1'b1;
					end
					INY, DEY: begin
						dp.reg_bus[BUS_ADD_SB] = 1'b1; // add -> y
						dp.reg_bus[BUS_SB_Y]   = 1'b1;
						dp.reg_bus[BUS_SB_DB]  = 1'b1;
						dp.flag_load[FLG_DBZ_Z] = 1'b1;
						dp.flag_load[FLG_DB7_N] = 1'b1;
					end
					default: ;
				endcase
			end
			////////////////////////////////////////
			// cycle 1, transfers and inc/dec
			////////////////////////////////////////
			CYCLE_W'(CYC_OPND): begin
				case (ir.raw)
					TAX, TAY: begin
						dp.reg_bus[BUS_AC_SB] = 1'b1; // ac on sb and db
						dp.reg_bus[BUS_AC_DB] = 1'b1;
						dp.reg_bus[BUS_SB_X]  = (ir.raw == TAX);
						dp.reg_bus[BUS_SB_Y]  = (ir.raw == TAY);
						dp.flag_load[FLG_DBZ_Z] = 1'b1;
						dp.flag_load[FLG_DB7_N] = 1'b1;
					end
					TXA, TYA: begin
						dp.reg_bus[BUS_X_SB]  = (ir.raw == TXA);
						dp.reg_bus[BUS_Y_SB]  = (ir.raw == TYA);
						dp.reg_bus[BUS_SB_DB] = 1'b1;
						dp.reg_bus[BUS_SB_AC] = 1'b1;
						dp.flag_load[FLG_DBZ_Z] = 1'b1;
						dp.flag_load[FLG_DB7_N] = 1'b1;
					end
					INX, DEX, INY, DEY: begin
						dp.reg_bus[BUS_X_SB]  = (ir.raw == INX) || (ir.raw == DEX);
						dp.reg_bus[BUS_Y_SB]  = (ir.raw == INY) || (ir.raw == DEY);
						dp.reg_bus[BUS_SB_DB] = 1'b1; // index reg into b via db
						dp.alu_in[ALU_DB_ADD] = 1'b1;
						// a = 0 plus carry gives +1, a = ~1 plus carry gives -1
						dp.alu_in[ALU_Z_ADD]    = (ir.raw == INX) || (ir.raw == INY);
						dp.alu_in[ALU_NONE_ADD] = (ir.raw == DEX) || (ir.raw == DEY);
						dp.alu_in[ALU_C_ONE]    = 1'b1;
						dp.sums = 1'b1;
					end
					ADC_ABS: begin
						dp.reg_bus[BUS_DL_DB]  = 1'b1; // low byte + 0, held in add
						dp.alu_in[ALU_DB_ADD]  = 1'b1;
						dp.alu_in[ALU_Z_ADD]   = 1'b1;
						dp.sums = 1'b1;
					end
					default: ;
				endcase
				dp.flag_load[FLG_IR5_C] = carry_op; // c <- opcode bit 5
			end
			default: ;
		endcase

		// add in the last cycle of adc/sbc, sbc takes the inverted operand
		if (alu_add) begin
			dp.reg_bus[BUS_DL_DB]  = 1'b1;
			dp.reg_bus[BUS_AC_SB]  = 1'b1;
			dp.alu_in[ALU_SB_ADD]  = 1'b1;
			dp.alu_in[ALU_DB_ADD]  = (ir.f.aaa != AAA_SBC);
			dp.alu_in[ALU_NDB_ADD] = (ir.f.aaa == AAA_SBC);
			dp.sums = 1'b1;
		end
	end

endmodule

/* cycle_counter.sv */
`timescale 1ns/10ps

module cycle_counter #(
	parameter int CYCLE_W = 3
) (
	input  logic               clk_ph2,
	input  logic               rst,      // active low
	input  logic               step_inc, // advance one cycle
	input  logic               step_rst, // instruction done
	output logic [CYCLE_W-1:0] cycle     // current instruction cycle
);
	import decoder_pkg::*;

	always_ff @(posedge clk_ph2) begin
		if (!rst || step_rst) begin
			cycle <= '0; // next opcode starts at 0
		end else if (step_inc) begin
			cycle <= cycle + CYCLE_W'(1);
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// both steps come from the address decoder through the control register
	a_step_excl: assert property (@(posedge clk_ph2) disable iff (!rst)
		!(step_inc && step_rst))
		else $error("cycle_counter: step_inc and step_rst together");

	// longest kept instruction is absolute, cycles 0..3
	a_cycle_max: assert property (@(posedge clk_ph2) disable iff (!rst)
		cycle <= CYCLE_W'(CYC_LAST))
		else $error("cycle_counter: cycle %0d past last", cycle);

endmodule

/* decoder_ifs.sv */
`timescale 1ns/10ps

// register bus, alu and flag half of the control word
interface datapath_ctl_if;
	import decoder_pkg::*;

	logic [REG_BUS_W-1:0] reg_bus;   // register to sb/db transfers
	logic [ALU_IN_W-1:0]  alu_in;    // alu a/b input select
	logic                 sums;      // alu add
	logic [FLAG_W-1:0]    flag_load; // status flag loads

	modport src (
		output reg_bus, alu_in, sums, flag_load
	);
	modport dst (
		input reg_bus, alu_in, sums, flag_load
	);

endinterface

// address bus, pc and cycle step half of the control word
interface address_ctl_if;
	import decoder_pkg::*;

	logic [ADDR_W-1:0] addr_drive; // adl/adh sources, abl/abh loads
	logic [PC_W-1:0]   pc_ctl;     // pc reload and increment
	logic              step_inc;   // next instruction cycle
	logic              step_rst;   // back to cycle 0

	modport src (
		output addr_drive, pc_ctl, step_inc, step_rst
	);
	modport dst (
		input addr_drive, pc_ctl, step_inc, step_rst
	);

endinterface

/* decoder_pkg.sv */
package decoder_pkg;

	////////////////////////////////////////
	// opcodes of the kept instruction set
	////////////////////////////////////////
	localparam logic [7:0] ADC_IMM = 8'h69; // adc #imm
	localparam logic [7:0] SBC_IMM = 8'he9; // sbc #imm
	localparam logic [7:0] ADC_ZPG = 8'h65; // adc zp
	localparam logic [7:0] ADC_ABS = 8'h6d; // adc abs
	localparam logic [7:0] SEC     = 8'h38;
	localparam logic [7:0] CLC     = 8'h18;
	localparam logic [7:0] INX     = 8'he8;
	localparam logic [7:0] INY     = 8'hc8;
	localparam logic [7:0] DEX     = 8'hca;
	localparam logic [7:0] DEY     = 8'h88;
	localparam logic [7:0] TAX     = 8'haa;
	localparam logic [7:0] TXA     = 8'h8a;
	localparam logic [7:0] TAY     = 8'ha8;
	localparam logic [7:0] TYA     = 8'h98;

	// opcode byte, whole or split into the aaa/bbb/cc fields
	typedef union packed {
		logic [7:0] raw; // whole-opcode matching
		struct packed {
			logic [2:0] aaa; // operation within group
			logic [2:0] bbb; // addressing mode
			logic [1:0] cc;  // group
		} f;
	} opcode_u;

	localparam logic [2:0] BBB_ZPG = 3'b001; // adc group modes
	localparam logic [2:0] BBB_IMM = 3'b010;
	localparam logic [2:0] BBB_ABS = 3'b011;
	localparam logic [2:0] AAA_SBC = 3'b111; // sbc in group one

	////////////////////////////////////////
	// instruction cycles
	////////////////////////////////////////
	localparam int CYC_FETCH = 0; // opcode fetch, result store
	localparam int CYC_OPND  = 1; // first operand byte
	localparam int CYC_ADDR  = 2; // zp data / abs high byte
	localparam int CYC_LAST  = 3; // abs data

	////////////////////////////////////////
	// bit positions in the control vectors
	////////////////////////////////////////
	localparam int REG_BUS_W = 10;
	localparam int BUS_DL_DB = 0, BUS_AC_SB = 1, BUS_AC_DB = 2, BUS_ADD_SB = 3, BUS_SB_AC = 4;
	localparam int BUS_SB_DB = 5, BUS_SB_X = 6, BUS_SB_Y = 7, BUS_X_SB = 8, BUS_Y_SB = 9;

	localparam int ALU_IN_W = 6;
	localparam int ALU_SB_ADD = 0, ALU_DB_ADD = 1, ALU_NDB_ADD = 2; // a and b inputs
	localparam int ALU_Z_ADD = 3, ALU_C_ONE = 4, ALU_NONE_ADD = 5;  // constants and carry in

	localparam int FLAG_W = 5;
	localparam int FLG_AVR_V = 0, FLG_ACR_C = 1, FLG_DBZ_Z = 2, FLG_DB7_N = 3, FLG_IR5_C = 4;

	localparam int ADDR_W = 8;
	localparam int ADR_PCL_ADL = 0, ADR_PCH_ADH = 1, ADR_DL_ADL = 2, ADR_DL_ADH = 3;
	localparam int ADR_ADD_ADL = 4, ADR_Z_ADH = 5, ADR_ADL_ABL = 6, ADR_ADH_ABH = 7;

	localparam int PC_W = 3;
	localparam int PC_PCL_PCL = 0, PC_PCH_PCH = 1, PC_I_PC = 2;

	localparam int CTL_W = REG_BUS_W + ALU_IN_W + 1 + FLAG_W + ADDR_W + PC_W; // whole word

	function automatic logic is_alu_op(opcode_u op);
		return op.raw inside {ADC_IMM, SBC_IMM, ADC_ZPG, ADC_ABS};
	endfunction

	// single byte instructions, pc is not advanced past them
	function automatic logic is_implied(opcode_u op);
		return op.raw inside {SEC, CLC, INX, INY, DEX, DEY, TAX, TXA, TAY, TYA};
	endfunction

	// cycle in which the alu add runs, from the mode field
	function automatic int alu_last_cycle(opcode_u op);
		case (op.f.bbb)
			BBB_IMM: return CYC_OPND;
			BBB_ZPG: return CYC_ADDR;
			BBB_ABS: return CYC_LAST;
			default: return CYC_OPND;
		endcase
	endfunction

endpackage
